/* filelist.f */
src/icache_pkg.sv
src/icache_sram.sv
src/icache_way.sv
src/icache_ctrl.sv
src/icache_select.sv
src/icache_top.sv
testbench/icache_mem_model.sv
testbench/icache_tb.sv

/* src/icache_ctrl.sv */
/*
  Request register, flush sweep and miss FSM of the instruction cache.
  One miss is outstanding at a time, fetches stall until its block returns.
  A flush pulse seen during a miss is held and started after the refill.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_ctrl #(
  parameter int CACHE_SIZE = 1024,
  parameter int NUM_WAY    = 4,
  localparam int NUM_SET   = CACHE_SIZE / (icache_pkg::BLK_SIZE / 8) / NUM_WAY,
  localparam int IDX_W     = $clog2(NUM_SET),
  localparam int TAG_W     = icache_pkg::XLEN - IDX_W - icache_pkg::BOFFSET
) (
  input  logic                        clk_i,
  input  logic                        rst_ni,
  input  logic                        flush_i,
  input  logic                        fetch_valid_i,
  input  logic [icache_pkg::XLEN-1:0] fetch_addr_i,
  input  logic                        any_hit_i,
  input  logic                        mem_req_ready_i,
  input  logic                        mem_res_valid_i,
  output logic                        fetch_ready_o,
  output logic                        lkp_valid_o,
  output logic [TAG_W-1:0]            req_tag_o,
  output logic [IDX_W-1:0]            rd_idx_o,
  output logic [IDX_W-1:0]            wr_idx_o,
  output logic                        fill_en_o,
  output logic [TAG_W-1:0]            fill_tag_o,
  output logic                        clr_en_o,
  output logic                        mem_req_valid_o,
  output logic [icache_pkg::XLEN-1:0] mem_req_addr_o
);

  import icache_pkg::*;

  ctrl_state_e      state_q;
  ctrl_state_e      state_d;
  logic [IDX_W-1:0] flush_cnt_q;
  logic             flush_pend_q;
  logic             req_valid_q;
  logic [XLEN-1:0]  req_addr_q;
  logic [IDX_W-1:0] fetch_idx;
  logic [IDX_W-1:0] req_idx;
  logic             miss_now;
  logic             flush_go;
  logic             accept;

  assign fetch_idx = fetch_addr_i[IDX_W+BOFFSET-1:BOFFSET];
  assign req_idx   = req_addr_q[IDX_W+BOFFSET-1:BOFFSET];

  // Lookup in compare stage found no way
  assign miss_now = (state_q == ST_LOOKUP) && req_valid_q && !any_hit_i;
  assign flush_go = flush_i || flush_pend_q;

  assign fetch_ready_o = (state_q == ST_LOOKUP) && !miss_now && !flush_go;
  assign accept        = fetch_valid_i && fetch_ready_o;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      ST_FLUSH: begin
        if (flush_cnt_q == IDX_W'(NUM_SET - 1)) begin
          state_d = ST_LOOKUP;
        end
      end
      ST_LOOKUP: begin
        if (miss_now) begin
          state_d = mem_req_ready_i ? ST_MISS_WAIT : ST_MISS_REQ;
        end else if (flush_go) begin
          state_d = ST_FLUSH;
        end
      end
      ST_MISS_REQ: begin
        if (mem_req_ready_i) begin
          state_d = ST_MISS_WAIT;
        end
      end
      ST_MISS_WAIT: begin
        if (mem_res_valid_i) begin
          state_d = ST_LOOKUP;
        end
      end
      default: state_d = ST_FLUSH;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      state_q      <= ST_FLUSH;
      flush_cnt_q  <= '0;
      flush_pend_q <= 1'b0;
      req_valid_q  <= 1'b0;
    end else begin
      state_q <= state_d;

      // One set per cycle while sweeping
      if (state_q == ST_FLUSH && state_d == ST_FLUSH) begin
        flush_cnt_q <= flush_cnt_q + 1'b1;
      end else begin
        flush_cnt_q <= '0;
      end

      if (state_d == ST_FLUSH) begin
        flush_pend_q <= 1'b0;
      end else if (flush_i && state_q != ST_FLUSH) begin
        flush_pend_q <= 1'b1;
      end

      // Held through a miss, dropped when the block arrives
      if (accept) begin
        req_valid_q <= 1'b1;
      end else if (state_q == ST_LOOKUP && !miss_now) begin
        req_valid_q <= 1'b0;
      end else if (fill_en_o) begin
        req_valid_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept) begin
      req_addr_q <= fetch_addr_i;
    end
  end

  // New address goes to the arrays on accept, else the held one
  assign rd_idx_o = accept ? fetch_idx : req_idx;
  assign wr_idx_o = (state_q == ST_FLUSH) ? flush_cnt_q : req_idx;

  assign lkp_valid_o = req_valid_q;
  assign req_tag_o   = req_addr_q[XLEN-1:IDX_W+BOFFSET];
  assign fill_tag_o  = req_addr_q[XLEN-1:IDX_W+BOFFSET];
  assign clr_en_o    = (state_q == ST_FLUSH);
  assign fill_en_o   = (state_q == ST_MISS_WAIT) && mem_res_valid_i;

  assign mem_req_valid_o = miss_now || (state_q == ST_MISS_REQ);
  assign mem_req_addr_o  = {req_addr_q[XLEN-1:BOFFSET], {BOFFSET{1'b0}}};

  // Downstream request holds until taken
  a_mem_req_stable: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem_req_valid_o && !mem_req_ready_i |=> mem_req_valid_o && $stable(mem_req_addr_o)
  );

endmodule

`default_nettype wire

/* src/icache_pkg.sv */
/*
  Shared constants and types for the instruction cache.
  The block is fixed at four 32-bit words. BOFFSET must match BLK_SIZE.
*/
`default_nettype none

package icache_pkg;

  // Fetch address width
  localparam int XLEN = 32;

  // Bits per cache block, four instruction words
  localparam int BLK_SIZE = 128;

  // Byte offset bits inside one block
  localparam int BOFFSET = $clog2(BLK_SIZE / 8);

  // Controller states
  typedef enum logic [1:0] {
    ST_FLUSH     = 2'd0,
    ST_LOOKUP    = 2'd1,
    ST_MISS_REQ  = 2'd2,
    ST_MISS_WAIT = 2'd3
  } ctrl_state_e;

endpackage

`default_nettype wire

/* src/icache_select.sv */
/*
  Way selector: hit mux, tree pseudo-LRU state and victim choice.
  NUM_WAY must be a power of two, at least 2. PLRU bits are per set, in flops.
  Empty ways are filled lowest first before the tree is used.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_select #(
  parameter int CACHE_SIZE = 1024,
  parameter int NUM_WAY    = 4,
  localparam int NUM_SET   = CACHE_SIZE / (icache_pkg::BLK_SIZE / 8) / NUM_WAY,
  localparam int IDX_W     = $clog2(NUM_SET)
) (
  input  logic                                         clk_i,
  input  logic                                         rst_ni,
  input  logic                                         lkp_valid_i,
  input  logic                                         flushing_i,
  input  logic [IDX_W-1:0]                             idx_i,
  input  logic [NUM_WAY-1:0]                           way_hit_i,
  input  logic [NUM_WAY-1:0]                           way_valid_i,
  input  logic [NUM_WAY-1:0][icache_pkg::BLK_SIZE-1:0] way_data_i,
  input  logic                                         fill_en_i,
  input  logic [icache_pkg::BLK_SIZE-1:0]              mem_res_blk_i,
  output logic                                         any_hit_o,
  output logic [NUM_WAY-1:0]                           fill_way_o,
  output logic                                         resp_valid_o,
  output logic                                         resp_miss_o,
  output logic [icache_pkg::BLK_SIZE-1:0]              resp_blk_o
);

  import icache_pkg::*;

  localparam int LVL = $clog2(NUM_WAY);

  logic [NUM_WAY-2:0]  plru_q [NUM_SET];
  logic [NUM_WAY-1:0]  hit_vec;
  logic [NUM_WAY-1:0]  victim;
  logic [NUM_WAY-1:0]  touch_way;
  logic [BLK_SIZE-1:0] hit_blk;

  // Walk the tree, node bit 1 means the victim lies to the right
  function automatic logic [NUM_WAY-1:0] plru_victim(input logic [NUM_WAY-2:0] node);
    logic [NUM_WAY-1:0] oh;
    int                 n;
    int                 w;
    n = 0;
    w = 0;
    for (int l = 0; l < LVL; l++) begin
      w = 2 * w + int'(node[n]);
      n = 2 * n + 1 + int'(node[n]);
    end
    oh    = '0;
    oh[w] = 1'b1;
    return oh;
  endfunction

  // Point every node on the path away from the used way
  function automatic logic [NUM_WAY-2:0] plru_touch(input logic [NUM_WAY-2:0] node,
                                                    input logic [NUM_WAY-1:0] way_oh);
    logic [NUM_WAY-2:0] upd;
    logic               dir;
    int                 w;
    int                 n;
    upd = node;
    w   = 0;
    for (int i = 0; i < NUM_WAY; i++) begin
      if (way_oh[i]) begin
        w = i;
      end
    end
    n = 0;
    for (int l = 0; l < LVL; l++) begin
      dir    = w[LVL-1-l];
      upd[n] = ~dir;
      n      = 2 * n + 1 + int'(dir);
    end
    return upd;
  endfunction

  assign hit_vec   = lkp_valid_i ? way_hit_i : '0;
  assign any_hit_o = |hit_vec;

  always_comb begin
    hit_blk = '0;
    for (int i = 0; i < NUM_WAY; i++) begin
      if (hit_vec[i]) begin
        hit_blk = hit_blk | way_data_i[i];
      end
    end
  end

  // Lowest empty way first, else the tree's choice
  always_comb begin
    logic found_inv;
    found_inv = 1'b0;
    victim    = plru_victim(plru_q[idx_i]);
    for (int i = 0; i < NUM_WAY; i++) begin
      if (!found_inv && !way_valid_i[i]) begin
        victim    = '0;
        victim[i] = 1'b1;
        found_inv = 1'b1;
      end
    end
  end

  assign fill_way_o = victim;
  assign touch_way  = fill_en_i ? victim : hit_vec;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      for (int s = 0; s < NUM_SET; s++) begin
        plru_q[s] <= '0;
      end
    end else if (flushing_i) begin
      for (int s = 0; s < NUM_SET; s++) begin
        plru_q[s] <= '0;
      end
    end else if (fill_en_i || any_hit_o) begin
      plru_q[idx_i] <= plru_touch(plru_q[idx_i], touch_way);
    end
  end

  // Refill block bypasses the arrays on a miss
  assign resp_valid_o = any_hit_o || fill_en_i;
  assign resp_miss_o  = fill_en_i;
  assign resp_blk_o   = fill_en_i ? mem_res_blk_i : hit_blk;

  // A tag lives in at most one way of its set
  a_hit_onehot: assert property (
    @(posedge clk_i) disable iff (!rst_ni) lkp_valid_i |-> $onehot0(way_hit_i)
  );

endmodule

`default_nettype wire

/* src/icache_sram.sv */
/*
  Single-port memory with registered read, old data on a read during write.
  DEPTH must be at least 2. No reset, contents are X until written.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_sram #(
  parameter int WIDTH = 32,
  parameter int DEPTH = 16,
  localparam int AW   = $clog2(DEPTH)
) (
  input  logic             clk_i,
  input  logic [AW-1:0]    addr_i,
  input  logic             wr_en_i,
  input  logic [WIDTH-1:0] wdata_i,
  output logic [WIDTH-1:0] rdata_o
);

  logic [WIDTH-1:0] mem_q [DEPTH];

  always_ff @(posedge clk_i) begin
    if (wr_en_i) begin
      mem_q[addr_i] <= wdata_i;
    end
    // Read data shows up one edge after the address
    rdata_o <= mem_q[addr_i];
  end

endmodule

`default_nettype wire

/* src/icache_top.sv */
/*
  Set-associative instruction cache, read only, hits answered in one cycle.
  Sets are swept invalid for NUM_SET cycles after reset and after flush_i.
  CACHE_SIZE is in bytes; it must give at least 2 sets.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_top #(
  parameter int CACHE_SIZE = 1024,
  parameter int NUM_WAY    = 4
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            flush_i,
  input  logic                            fetch_valid_i,
  input  logic [icache_pkg::XLEN-1:0]     fetch_addr_i,
  output logic                            fetch_ready_o,
  output logic                            resp_valid_o,
  output logic                            resp_miss_o,
  output logic [icache_pkg::BLK_SIZE-1:0] resp_blk_o,
  output logic                            mem_req_valid_o,
  output logic [icache_pkg::XLEN-1:0]     mem_req_addr_o,
  input  logic                            mem_req_ready_i,
  input  logic                            mem_res_valid_i,
  input  logic [icache_pkg::BLK_SIZE-1:0] mem_res_blk_i
);

  import icache_pkg::*;

  localparam int NUM_SET = CACHE_SIZE / (BLK_SIZE / 8) / NUM_WAY;
  localparam int IDX_W   = $clog2(NUM_SET);
  localparam int TAG_W   = XLEN - IDX_W - BOFFSET;

  logic                              lkp_valid;
  logic [TAG_W-1:0]                  req_tag;
  logic [IDX_W-1:0]                  rd_idx;
  logic [IDX_W-1:0]                  wr_idx;
  logic                              fill_en;
  logic [TAG_W-1:0]                  fill_tag;
  logic                              clr_en;
  logic                              any_hit;
  logic [NUM_WAY-1:0]                fill_way;
  logic [NUM_WAY-1:0]                way_hit;
  logic [NUM_WAY-1:0]                way_valid;
  logic [NUM_WAY-1:0][BLK_SIZE-1:0]  way_data;

  icache_ctrl #(
    .CACHE_SIZE (CACHE_SIZE),
    .NUM_WAY    (NUM_WAY)
  ) u_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .flush_i         (flush_i),
    .fetch_valid_i   (fetch_valid_i),
    .fetch_addr_i    (fetch_addr_i),
    .any_hit_i       (any_hit),
    .mem_req_ready_i (mem_req_ready_i),
    .mem_res_valid_i (mem_res_valid_i),
    .fetch_ready_o   (fetch_ready_o),
    .lkp_valid_o     (lkp_valid),
    .req_tag_o       (req_tag),
    .rd_idx_o        (rd_idx),
    .wr_idx_o        (wr_idx),
    .fill_en_o       (fill_en),
    .fill_tag_o      (fill_tag),
    .clr_en_o        (clr_en),
    .mem_req_valid_o (mem_req_valid_o),
    .mem_req_addr_o  (mem_req_addr_o)
  );

  for (genvar w = 0; w < NUM_WAY; w++) begin : g_way
    icache_way #(
      .CACHE_SIZE (CACHE_SIZE),
      .NUM_WAY    (NUM_WAY)
    ) u_way (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .rd_idx_i   (rd_idx),
      .wr_idx_i   (wr_idx),
      .fill_en_i  (fill_en),
      .fill_sel_i (fill_way[w]),
      .fill_tag_i (fill_tag),
      .fill_blk_i (mem_res_blk_i),
      .clr_en_i   (clr_en),
      .req_tag_i  (req_tag),
      .hit_o      (way_hit[w]),
      .valid_o    (way_valid[w]),
      .data_o     (way_data[w])
    );
  end

  // Lookup index is the held request, which is also the refill index
  icache_select #(
    .CACHE_SIZE (CACHE_SIZE),
    .NUM_WAY    (NUM_WAY)
  ) u_select (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .lkp_valid_i   (lkp_valid),
    .flushing_i    (clr_en),
    .idx_i         (wr_idx),
    .way_hit_i     (way_hit),
    .way_valid_i   (way_valid),
    .way_data_i    (way_data),
    .fill_en_i     (fill_en),
    .mem_res_blk_i (mem_res_blk_i),
    .any_hit_o     (any_hit),
    .fill_way_o    (fill_way),
    .resp_valid_o  (resp_valid_o),
    .resp_miss_o   (resp_miss_o),
    .resp_blk_o    (resp_blk_o)
  );

endmodule

`default_nettype wire

/* src/icache_way.sv */
/*
  One way of the cache: tag array with valid bit, data array, tag compare.
  hit_o, valid_o and data_o refer to the set read at the previous edge.
  A fill or clear redirects the arrays to wr_idx_i for that cycle.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_way #(
  parameter int CACHE_SIZE = 1024,
  parameter int NUM_WAY    = 4,
  localparam int NUM_SET   = CACHE_SIZE / (icache_pkg::BLK_SIZE / 8) / NUM_WAY,
  localparam int IDX_W     = $clog2(NUM_SET),
  localparam int TAG_W     = icache_pkg::XLEN - IDX_W - icache_pkg::BOFFSET
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic [IDX_W-1:0]                rd_idx_i,
  input  logic [IDX_W-1:0]                wr_idx_i,
  input  logic                            fill_en_i,
  input  logic                            fill_sel_i,
  input  logic [TAG_W-1:0]                fill_tag_i,
  input  logic [icache_pkg::BLK_SIZE-1:0] fill_blk_i,
  input  logic                            clr_en_i,
  input  logic [TAG_W-1:0]                req_tag_i,
  output logic                            hit_o,
  output logic                            valid_o,
  output logic [icache_pkg::BLK_SIZE-1:0] data_o
);

  import icache_pkg::*;

  logic [IDX_W-1:0] arr_idx;
  logic             fill_we;
  logic             tag_we;
  logic [TAG_W:0]   tag_wdata;
  logic [TAG_W:0]   tag_rdata;

  // Only the selected way takes the refill block
  assign fill_we = fill_en_i & fill_sel_i;
  assign tag_we  = fill_we | clr_en_i;
  assign arr_idx = (fill_en_i || clr_en_i) ? wr_idx_i : rd_idx_i;

  // Valid bit sits above the tag
  assign tag_wdata = clr_en_i ? '0 : {1'b1, fill_tag_i};

  icache_sram #(
    .WIDTH (TAG_W + 1),
    .DEPTH (NUM_SET)
  ) u_tag_sram (
    .clk_i   (clk_i),
    .addr_i  (arr_idx),
    .wr_en_i (tag_we),
    .wdata_i (tag_wdata),
    .rdata_o (tag_rdata)
  );

  icache_sram #(
    .WIDTH (BLK_SIZE),
    .DEPTH (NUM_SET)
  ) u_data_sram (
    .clk_i   (clk_i),
    .addr_i  (arr_idx),
    .wr_en_i (fill_we),
    .wdata_i (fill_blk_i),
    .rdata_o (data_o)
  );

  assign valid_o = tag_rdata[TAG_W];
  assign hit_o   = valid_o && (tag_rdata[TAG_W-1:0] == req_tag_i);

  // Sweep and refill are separate controller states
  a_fill_clr_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni) !(fill_en_i && clr_en_i)
  );

endmodule

`default_nettype wire

/* testbench/icache_mem_model.sv */
/*
  Lower memory model for the instruction cache testbench.
  Ready comes 0 to 3 cycles after a request appears, with no delay it is
  already up. The block follows 1 to 4 cycles after the handshake.
  Word j of a block is its base address plus 4*j.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_mem_model (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            req_valid_i,
  input  logic [icache_pkg::XLEN-1:0]     req_addr_i,
  input  logic [icache_pkg::XLEN-1:0]     exp_addr_i,
  output logic                            req_ready_o,
  output logic                            res_valid_o,
  output logic [icache_pkg::BLK_SIZE-1:0] res_blk_o,
  output logic                            err_o
);

  import icache_pkg::*;

  integer          seed;
  int              ready_dly;
  int              lat;
  logic [XLEN-1:0] blk_addr;

  function automatic logic [BLK_SIZE-1:0] make_block(input logic [XLEN-1:0] base);
    logic [BLK_SIZE-1:0] blk;
    for (int j = 0; j < BLK_SIZE / 32; j++) begin
      blk[32*j +: 32] = base + 32'(4 * j);
    end
    return blk;
  endfunction

  initial begin
    seed        = 32'he66c;
    res_valid_o = 1'b0;
    res_blk_o   = '0;
    err_o       = 1'b0;
    ready_dly   = $unsigned($random(seed)) % 4;
    forever begin
      // No delay means the request is taken in its first cycle
      req_ready_o = (ready_dly == 0);
      @(negedge clk_i);
      if (rst_ni && req_valid_i) begin
        if (ready_dly > 0) begin
          repeat (ready_dly) begin
            @(posedge clk_i);
          end
          #1;
          req_ready_o = 1'b1;
          @(negedge clk_i);
        end
        // Handshake happens at the coming edge
        blk_addr = req_addr_i;
        assert (req_valid_i && blk_addr == {exp_addr_i[XLEN-1:BOFFSET], {BOFFSET{1'b0}}})
        else begin
          $display("mismatch at %0t ns: mem_req_addr_o %h valid %b, expected %h",
                   $time, blk_addr, req_valid_i, exp_addr_i);
          err_o = 1'b1;
        end
        @(posedge clk_i);
        #1;
        req_ready_o = 1'b0;
        lat = 1 + $unsigned($random(seed)) % 4;
        repeat (lat - 1) begin
          @(posedge clk_i);
          #1;
        end
        res_valid_o = 1'b1;
        res_blk_o   = make_block({blk_addr[XLEN-1:BOFFSET], {BOFFSET{1'b0}}});
        @(posedge clk_i);
        #1;
        res_valid_o = 1'b0;
        res_blk_o   = '0;
        ready_dly   = $unsigned($random(seed)) % 4;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/icache_tb.sv */
/*
  Testbench for the instruction cache with default parameters.
  Rows of the stimulus table run one fetch at a time, except rows marked
  as burst, which are issued back to back and must all hit.
*/
`timescale 1ns/1ps
`default_nettype none

module icache_tb;

  import icache_pkg::*;

  localparam int NUM_SET    = 16;
  localparam int WAIT_LIMIT = 200;

  logic                clk;
  logic                rst_n;
  logic                flush;
  logic                fetch_valid;
  logic [XLEN-1:0]     fetch_addr;
  logic                fetch_ready;
  logic                resp_valid;
  logic                resp_miss;
  logic [BLK_SIZE-1:0] resp_blk;
  logic                mem_req_valid;
  logic [XLEN-1:0]     mem_req_addr;
  logic                mem_req_ready;
  logic                mem_res_valid;
  logic [BLK_SIZE-1:0] mem_res_blk;
  logic                mem_err;
  logic [XLEN-1:0]     exp_req_addr;

  // Stimulus table columns
  logic [XLEN-1:0] tbl_addr  [$];
  logic            tbl_miss  [$];
  logic            tbl_flush [$];
  logic            tbl_burst [$];

  always #10 clk = ~clk;

  icache_top dut0 (
    .clk_i           (clk),
    .rst_ni          (rst_n),
    .flush_i         (flush),
    .fetch_valid_i   (fetch_valid),
    .fetch_addr_i    (fetch_addr),
    .fetch_ready_o   (fetch_ready),
    .resp_valid_o    (resp_valid),
    .resp_miss_o     (resp_miss),
    .resp_blk_o      (resp_blk),
    .mem_req_valid_o (mem_req_valid),
    .mem_req_addr_o  (mem_req_addr),
    .mem_req_ready_i (mem_req_ready),
    .mem_res_valid_i (mem_res_valid),
    .mem_res_blk_i   (mem_res_blk)
  );

  icache_mem_model mem0 (
    .clk_i       (clk),
    .rst_ni      (rst_n),
    .req_valid_i (mem_req_valid),
    .req_addr_i  (mem_req_addr),
    .exp_addr_i  (exp_req_addr),
    .req_ready_o (mem_req_ready),
    .res_valid_o (mem_res_valid),
    .res_blk_o   (mem_res_blk),
    .err_o       (mem_err)
  );

  task automatic abort_run(input string msg);
    $display("%s", msg);
    $display("Some tests failed");
    $fatal(1);
  endtask

  // Address errors flagged by the memory model
  always @(posedge clk) begin
    assert (!mem_err) else abort_run("memory model saw a wrong block request");
  end

  function automatic logic [BLK_SIZE-1:0] block_for(input logic [XLEN-1:0] addr);
    logic [BLK_SIZE-1:0] blk;
    logic [XLEN-1:0]     base;
    base = {addr[XLEN-1:4], 4'h0};
    for (int j = 0; j < 4; j++) begin
      blk[32*j +: 32] = base + 32'(4 * j);
    end
    return blk;
  endfunction

  task automatic add_row(input logic [XLEN-1:0] addr, input logic miss,
                         input logic flush_first, input logic burst);
    tbl_addr.push_back(addr);
    tbl_miss.push_back(miss);
    tbl_flush.push_back(flush_first);
    tbl_burst.push_back(burst);
  endtask

  task automatic load_table();
    // First fetch, then the same block again
    add_row(32'h0000_1004, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_1004, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_100c, 1'b0, 1'b0, 1'b0);
    // Tags A B C D fill set 5
    add_row(32'h0000_1050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_2050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_3050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_4050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_1054, 1'b0, 1'b0, 1'b0);
    // E evicts C
    add_row(32'h0000_5050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_3058, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_105c, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_4054, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_5050, 1'b0, 1'b0, 1'b0);
    // After a flush everything misses once
    add_row(32'h0000_1004, 1'b1, 1'b1, 1'b0);
    add_row(32'h0000_1050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_5050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_4050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_3050, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_100c, 1'b0, 1'b0, 1'b0);
    add_row(32'h0000_2110, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_3220, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_4330, 1'b1, 1'b0, 1'b0);
    add_row(32'h0000_5440, 1'b1, 1'b0, 1'b0);
    // Back-to-back hits over several sets
    add_row(32'h0000_2114, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_3228, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_433c, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_5440, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_1008, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_1058, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_2118, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_5054, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_3050, 1'b0, 1'b0, 1'b1);
    add_row(32'h0000_4058, 1'b0, 1'b0, 1'b1);
  endtask

  task automatic check_resp(input logic [XLEN-1:0] addr, input logic exp_miss);
    logic [BLK_SIZE-1:0] exp_blk;
    exp_blk = block_for(addr);
    assert (resp_miss === exp_miss) else
      abort_run($sformatf("mismatch at %0t ns: addr %h resp_miss_o %b, expected %b",
                          $time, addr, resp_miss, exp_miss));
    assert (resp_blk === exp_blk) else
      abort_run($sformatf("mismatch at %0t ns: addr %h resp_blk_o %h, expected %h",
                          $time, addr, resp_blk, exp_blk));
  endtask

  task automatic wait_ready();
    int cnt;
    cnt = 0;
    @(negedge clk);
    while (!fetch_ready && cnt < WAIT_LIMIT) begin
      @(negedge clk);
      cnt++;
    end
    assert (fetch_ready) else abort_run("timeout waiting for fetch_ready_o");
  endtask

  task automatic wait_resp(output int cycles);
    cycles = 0;
    @(negedge clk);
    while (!resp_valid && cycles < WAIT_LIMIT) begin
      @(negedge clk);
      cycles++;
    end
    assert (resp_valid) else abort_run("timeout waiting for resp_valid_o");
  endtask

  // Sweep keeps the core and memory sides quiet for NUM_SET cycles
  task automatic wait_sweep();
    int low;
    low = 0;
    @(negedge clk);
    while (!fetch_ready && low < WAIT_LIMIT) begin
      assert (!resp_valid && !mem_req_valid) else
        abort_run("response or memory request seen during the flush sweep");
      low++;
      @(negedge clk);
    end
    assert (fetch_ready) else abort_run("timeout waiting for the flush sweep to end");
    assert (low == NUM_SET) else
      abort_run($sformatf("mismatch at %0t ns: sweep took %0d cycles, expected %0d",
                          $time, low, NUM_SET));
  endtask

  task automatic flush_cache();
    @(posedge clk);
    #1;
    flush = 1'b1;
    @(posedge clk);
    #1;
    flush = 1'b0;
    wait_sweep();
  endtask

  task automatic fetch_one(input int row);
    int lag;
    @(posedge clk);
    #1;
    fetch_valid  = 1'b1;
    fetch_addr   = tbl_addr[row];
    exp_req_addr = tbl_addr[row];
    wait_ready();
    @(posedge clk);
    #1;
    fetch_valid = 1'b0;
    wait_resp(lag);
    check_resp(tbl_addr[row], tbl_miss[row]);
    if (!tbl_miss[row]) begin
      assert (lag == 0) else
        abort_run($sformatf("mismatch at %0t ns: hit answered %0d cycles late", $time, lag));
    end
  endtask

  task automatic fetch_burst(input int first, input int last);
    int issued;
    int done;
    int cyc;
    issued = first;
    done   = first;
    cyc    = 0;
    @(posedge clk);
    #1;
    fetch_valid = 1'b1;
    fetch_addr  = tbl_addr[first];
    while (done <= last && cyc < WAIT_LIMIT) begin
      @(negedge clk);
      if (resp_valid) begin
        check_resp(tbl_addr[done], tbl_miss[done]);
        done++;
      end
      // Each hit answers one cycle after its acceptance
      assert (done == issued) else abort_run("response missing in back-to-back run");
      if (fetch_valid) begin
        assert (fetch_ready) else abort_run("fetch_ready_o low during back-to-back hits");
        issued++;
      end
      @(posedge clk);
      #1;
      fetch_valid = (issued <= last);
      if (issued <= last) begin
        fetch_addr = tbl_addr[issued];
      end
      cyc++;
    end
    assert (done > last) else abort_run("timeout waiting for back-to-back responses");
  endtask

  initial begin
    int row;
    int last;
    clk          = 1'b0;
    rst_n        = 1'b0;
    flush        = 1'b0;
    fetch_valid  = 1'b0;
    fetch_addr   = '0;
    exp_req_addr = '0;
    load_table();
    repeat (5) @(posedge clk);
    #1;
    rst_n = 1'b1;
    wait_sweep();
    row = 0;
    while (row < tbl_addr.size()) begin
      if (tbl_flush[row]) begin
        flush_cache();
      end
      if (tbl_burst[row]) begin
        last = row;
        while (last + 1 < tbl_addr.size() && tbl_burst[last + 1]) begin
          last++;
        end
        fetch_burst(row, last);
        row = last + 1;
      end else begin
        fetch_one(row);
        row++;
      end
    end
    $display("All tests passed");
    $finish;
  end

endmodule

`default_nettype wire
